//--- bench/pdpExecUnitTb.sv
// Testbench for the execution unit
// Drives a random opcode stream with gaps, multi-flag and stalled decodes,
// models the memory and checks the final memory image, while the bound
// checker does the cycle-level checking
`timescale 1ns/100ps
`default_nettype none

module pdpExecUnitTb;

    localparam int numInstr = 200;
    localparam int resetCycles = 4;
    // Worst case per instruction is gap, longest stall and two drive cycles
    localparam int maxCycles = numInstr * 10 + resetCycles + 100;

    logic clk = 1'b0;
    logic reset_n;
    pdpExecPkg::memOpcode memCode;
    pdpExecPkg::op7Opcode op7Code;
    logic [11:0] rdData = '0;
    pdpExecPkg::memRequest memBus;
    logic stall;
    logic [11:0] pcValue;
    logic [11:0] accValue;
    logic linkValue;
    logic illegalInstr;

    logic [11:0] mem [4096];
    logic [11:0] refMem [4096];
    logic [31:0] lfsrState;
    logic [12:0] flagsNow;
    int cycleCount = 0;
    int errorCount = 0;

    always #50 clk = ~clk;

    pdpExecUnit UUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .memCode      (memCode),
        .op7Code      (op7Code),
        .rdData       (rdData),
        .memBus       (memBus),
        .stall        (stall),
        .pcValue      (pcValue),
        .accValue     (accValue),
        .linkValue    (linkValue),
        .illegalInstr (illegalInstr)
    );

    // Galois LFSR stepped once per bit taken
    function automatic int randBits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            value = (value << 1) | lfsrState[0];
        end
        return value;
    endfunction

    // One flag and now and then a second one that makes the decode illegal
    function automatic logic [12:0] pickFlags();
        int first;
        int second;
        logic [12:0] f;
        first = randBits(4) % 13;
        f = 13'd1 << first;
        if (randBits(3) == 0) begin
            second = (first + 1 + randBits(3)) % 13;
            f = f | (13'd1 << second);
        end
        return f;
    endfunction

    task automatic presentInstr(input logic [12:0] f, input logic [11:0] addr);
        @(posedge clk);
        memCode <= {f[12:7], addr};
        op7Code <= f[6:0];
        @(posedge clk);
        memCode <= '0;
        op7Code <= '0;
    endtask

    // Memory answers a read in the next cycle and writes at the end of wrReq
    always @(posedge clk) begin
        if (memBus.rdReq) begin
            rdData <= mem[memBus.address];
        end
        if (memBus.wrReq) begin
            mem[memBus.address] <= memBus.wrData;
        end
    end

    // Expected memory image updated on each accepted store instruction
    assign flagsNow = {memCode.opAnd, memCode.opTad, memCode.opIsz,
                       memCode.opDca, memCode.opJms, memCode.opJmp, op7Code};

    always @(posedge clk) begin
        if (reset_n && !stall && $countones(flagsNow) == 1) begin
            case (1'b1)
                memCode.opIsz: refMem[memCode.memInstAddr] = refMem[memCode.memInstAddr] + 12'd1;
                memCode.opDca: refMem[memCode.memInstAddr] = UUT.checks.shAcc;
                memCode.opJms: refMem[memCode.memInstAddr] = UUT.checks.shPc + 12'd1;
                default: begin
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Run stopped at %0t: cycle limit of %0d reached", $time, maxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int gap;
        logic [12:0] f;
        logic [11:0] addr;
        lfsrState = 32'h3621;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = randBits(12);
            // Low words hold 7777 so an ISZ there wraps to zero and skips
            if (a < 16) begin
                mem[a] = 12'o7777;
            end
            refMem[a] = mem[a];
        end
        reset_n = 1'b0;
        memCode = '0;
        op7Code = '0;
        repeat (resetCycles) @(posedge clk);
        reset_n <= 1'b1;

        for (int i = 0; i < numInstr; i++) begin
            gap = randBits(2);
            repeat (gap) @(posedge clk);
            // Now and then present while stalled so the unit has to ignore it
            if (randBits(3) != 0) begin
                @(negedge clk);
                while (stall) @(negedge clk);
            end
            f = pickFlags();
            addr = randBits(12);
            // Half of the lone ISZs go to the low words
            if (f == 13'h0400 && randBits(1) != 0) begin
                addr = randBits(4);
            end
            presentInstr(f, addr);
        end

        @(negedge clk);
        while (stall) @(negedge clk);
        repeat (3) @(posedge clk);

        for (int a = 0; a < 4096; a++) begin
            if (mem[a] !== refMem[a]) begin
                $display("FAILED at %0t: memory word %o holds %o, expected %o",
                         $time, a, mem[a], refMem[a]);
                errorCount++;
            end
        end

        $display("Assertion failures: %0d, memory mismatches: %0d",
                 UUT.checks.failCount, errorCount);
        if (UUT.checks.failCount + errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/pdpExecUnit_assert.sv
// Checker bound to the execution unit top level
// Keeps a shadow PC, accumulator and link from the accepted opcodes and
// the returned memory words, and compares the unit's outputs against them
`timescale 1ns/100ps
`default_nettype none

module pdpExecUnit_assert (
    input wire logic                                clk,
    input wire logic                                reset_n,
    input wire pdpExecPkg::memOpcode                memCode,
    input wire pdpExecPkg::op7Opcode                op7Code,
    input wire logic [pdpExecPkg::dataWidth-1:0]    rdData,
    input wire pdpExecPkg::memRequest               memBus,
    input wire logic                                stall,
    input wire logic [pdpExecPkg::addrWidth-1:0]    pcValue,
    input wire logic [pdpExecPkg::dataWidth-1:0]    accValue,
    input wire logic                                linkValue,
    input wire logic                                illegalInstr
);

    int failCount = 0;
    logic [12:0] flags;
    logic accepting;
    logic [12:0] curFlags;
    logic [11:0] curAddr;
    logic [2:0] shadowLeft;
    logic [2:0] stepIdx;
    logic [11:0] shPc;
    logic [11:0] shAcc;
    logic shLink;
    logic illegalSeen;
    logic [11:0] iszNext;
    logic expRd;
    logic expWr;
    logic [11:0] expWrData;

    // Bit 12 is AND down to bit 7 JMP, then NOP down to CLA CLL
    assign flags = {memCode.opAnd, memCode.opTad, memCode.opIsz,
                    memCode.opDca, memCode.opJms, memCode.opJmp, op7Code};
    assign accepting = reset_n && !stall && ($countones(flags) == 1);
    assign iszNext = rdData + 12'd1;

    function automatic logic [2:0] cyclesFor(input logic [12:0] f);
        if (f[12] || f[11]) begin
            return pdpExecPkg::andTadCycles;
        end else if (f[10]) begin
            return pdpExecPkg::iszCycles;
        end
        return pdpExecPkg::shortCycles;
    endfunction

    // Step 2 is the cycle after E1, step 4 the cycle after E3
    assign expRd = (shadowLeft != 0) && (stepIdx == 3'd2) &&
                   (curFlags[12] || curFlags[11] || curFlags[10]);
    assign expWr = (shadowLeft != 0) &&
                   (((stepIdx == 3'd2) && (curFlags[9] || curFlags[8])) ||
                    ((stepIdx == 3'd4) && curFlags[10]));
    assign expWrData = curFlags[9] ? shAcc : (curFlags[8] ? shPc + 12'd1 : iszNext);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            shadowLeft <= '0;
            stepIdx <= '0;
            shPc <= pdpExecPkg::startAddress;
            shAcc <= '0;
            shLink <= 1'b0;
            illegalSeen <= 1'b0;
        end else begin
            illegalSeen <= !stall && ($countones(flags) > 1);
            if (accepting) begin
                curFlags <= flags;
                curAddr <= memCode.memInstAddr;
                shadowLeft <= cyclesFor(flags);
                stepIdx <= 3'd1;
            end else if (shadowLeft != 0) begin
                shadowLeft <= shadowLeft - 3'd1;
                stepIdx <= stepIdx + 3'd1;
                if (shadowLeft == 3'd1) begin
                    shPc <= shPc + 12'd1;
                    case (1'b1)
                        curFlags[12]: shAcc <= shAcc & rdData;
                        curFlags[11]: {shLink, shAcc} <= {shLink, shAcc} + {1'b0, rdData};
                        curFlags[10]: if (iszNext == 12'd0) shPc <= shPc + 12'd2;
                        curFlags[9]:  shAcc <= '0;
                        curFlags[8]:  shPc <= curAddr + 12'd1;
                        curFlags[7]:  shPc <= curAddr;
                        curFlags[5]:  {shLink, shAcc} <= {shLink, shAcc} + 13'd1;
                        curFlags[4]:  shAcc <= ~shAcc;
                        curFlags[3]:  shLink <= ~shLink;
                        curFlags[2]:  shLink <= 1'b0;
                        curFlags[1]:  shAcc <= '0;
                        curFlags[0]: begin
                            shAcc <= '0;
                            shLink <= 1'b0;
                        end
                        default: begin
                        end
                    endcase
                end
            end
        end
    end

    resetValues: assert property (@(posedge clk) !reset_n |=>
        (!stall && !memBus.rdReq && !memBus.wrReq && !illegalInstr &&
         pcValue == pdpExecPkg::startAddress && accValue == '0 && !linkValue))
        else begin
            failCount++;
            $error("state after reset is wrong");
        end

    stallLength: assert property (@(posedge clk) disable iff (!reset_n)
        stall == (shadowLeft != 0))
        else begin
            failCount++;
            $error("stall does not match instruction length");
        end

    stateOnIdle: assert property (@(posedge clk) disable iff (!reset_n)
        (shadowLeft == 0) |-> (pcValue == shPc && accValue == shAcc && linkValue == shLink))
        else begin
            failCount++;
            $error("PC, AC or link differ from shadow");
        end

    readRequest: assert property (@(posedge clk) disable iff (!reset_n)
        memBus.rdReq == expRd && (!memBus.rdReq || memBus.address == curAddr))
        else begin
            failCount++;
            $error("read request wrong in time or address");
        end

    writeRequest: assert property (@(posedge clk) disable iff (!reset_n)
        memBus.wrReq == expWr)
        else begin
            failCount++;
            $error("write request wrong in time");
        end

    writeContents: assert property (@(posedge clk) disable iff (!reset_n)
        memBus.wrReq |-> (memBus.address == curAddr && memBus.wrData == expWrData))
        else begin
            failCount++;
            $error("write address or data wrong");
        end

    illegalPulse: assert property (@(posedge clk) disable iff (!reset_n)
        illegalInstr == illegalSeen)
        else begin
            failCount++;
            $error("illegalInstr does not match multi-flag decode");
        end

endmodule

bind pdpExecUnit pdpExecUnit_assert checks (.*);

`default_nettype wire

//--- design/execSequencer.sv
// Processing stage of the execution unit
// Owns the program counter, accumulator and link. A step counter runs for
// the cycle count of the accepted command, memory requests are posted one
// cycle ahead of the port register and all state updates on the final step
`timescale 1ns/100ps
`default_nettype none

module execSequencer (
    input  wire logic                                   clk,
    input  wire logic                                   reset_n,
    input  wire pdpExecPkg::execCommand                 command,
    input  wire logic                                   cmdValid,
    input  wire logic [pdpExecPkg::dataWidth-1:0]       rdDataSeen,
    output logic                                        busy,
    output pdpExecPkg::memRequest                       memReq,
    output logic [pdpExecPkg::addrWidth-1:0]            pcValue,
    output logic [pdpExecPkg::dataWidth-1:0]            accValue,
    output logic                                        linkValue
);

    logic [pdpExecPkg::stepWidth-1:0] stepCount;
    logic [pdpExecPkg::stepWidth-1:0] loadCount;
    logic finalStep;
    logic iszWriteStep;
    logic [pdpExecPkg::addrWidth-1:0] pcPlusOne;
    logic [pdpExecPkg::addrWidth-1:0] pcPlusTwo;
    logic [pdpExecPkg::dataWidth-1:0] iszValue;
    logic [pdpExecPkg::dataWidth:0] tadSum;
    logic [pdpExecPkg::dataWidth:0] incSum;

    // Counter is loaded on the edge that ends the cmdValid cycle,
    // so one cycle of the count is already spent at load time
    always_comb begin
        case (command.op)
            pdpExecPkg::execAnd,
            pdpExecPkg::execTad: loadCount = pdpExecPkg::andTadCycles - 1'b1;
            pdpExecPkg::execIsz: loadCount = pdpExecPkg::iszCycles - 1'b1;
            default:             loadCount = pdpExecPkg::shortCycles - 1'b1;
        endcase
    end

    assign busy = cmdValid || (stepCount != '0);
    assign finalStep = (stepCount == 3'd1);

    // ISZ write goes out two steps after the read
    assign iszWriteStep = (command.op == pdpExecPkg::execIsz) &&
                          (stepCount == pdpExecPkg::iszCycles - 3'd2);

    assign pcPlusOne = pcValue + 1'b1;
    assign pcPlusTwo = pcValue + 2'd2;
    assign iszValue = rdDataSeen + 1'b1;
    assign tadSum = {linkValue, accValue} + {1'b0, rdDataSeen};
    assign incSum = {linkValue, accValue} + 1'b1;

    // Request posting, the port register delays it by one cycle
    always_comb begin
        memReq = '0;
        memReq.address = command.operand;
        if (cmdValid) begin
            case (command.op)
                pdpExecPkg::execAnd,
                pdpExecPkg::execTad,
                pdpExecPkg::execIsz: begin
                    memReq.rdReq = 1'b1;
                end
                pdpExecPkg::execDca: begin
                    memReq.wrReq = 1'b1;
                    memReq.wrData = accValue;
                end
                pdpExecPkg::execJms: begin
                    // Return address goes into the subroutine's first word
                    memReq.wrReq = 1'b1;
                    memReq.wrData = pcPlusOne;
                end
                default: begin
                end
            endcase
        end else if (iszWriteStep) begin
            memReq.wrReq = 1'b1;
            memReq.wrData = iszValue;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stepCount <= '0;
            pcValue <= pdpExecPkg::startAddress;
            accValue <= '0;
            linkValue <= 1'b0;
        end else begin
            if (cmdValid) begin
                stepCount <= loadCount;
            end else if (stepCount != '0) begin
                stepCount <= stepCount - 1'b1;
            end

            if (finalStep) begin
                pcValue <= pcPlusOne;
                case (command.op)
                    pdpExecPkg::execAnd: begin
                        accValue <= accValue & rdDataSeen;
                    end
                    pdpExecPkg::execTad: begin
                        {linkValue, accValue} <= tadSum;
                    end
                    pdpExecPkg::execIsz: begin
                        // Skip the next instruction when the counter wrapped to zero
                        if (iszValue == '0) begin
                            pcValue <= pcPlusTwo;
                        end
                    end
                    pdpExecPkg::execDca: begin
                        accValue <= '0;
                    end
                    pdpExecPkg::execJms: begin
                        pcValue <= command.operand + 1'b1;
                    end
                    pdpExecPkg::execJmp: begin
                        pcValue <= command.operand;
                    end
                    pdpExecPkg::execIac: begin
                        {linkValue, accValue} <= incSum;
                    end
                    pdpExecPkg::execCma: begin
                        accValue <= ~accValue;
                    end
                    pdpExecPkg::execCml: begin
                        linkValue <= ~linkValue;
                    end
                    pdpExecPkg::execCll: begin
                        linkValue <= 1'b0;
                    end
                    pdpExecPkg::execCla1: begin
                        accValue <= '0;
                    end
                    pdpExecPkg::execClaCll: begin
                        accValue <= '0;
                        linkValue <= 1'b0;
                    end
                    default: begin
                        // NOP only advances the PC
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/instrIntake.sv
// Input stage of the execution unit
// Samples the decoder flags while the unit is idle, checks that exactly one
// flag is set and hands one command with a single-cycle valid to the sequencer
`timescale 1ns/100ps
`default_nettype none

module instrIntake (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire pdpExecPkg::memOpcode   memCode,
    input  wire pdpExecPkg::op7Opcode   op7Code,
    input  wire logic                   busy,
    output pdpExecPkg::execCommand      command,
    output logic                        cmdValid,
    output logic                        illegalInstr
);

    logic [12:0] allFlags;
    logic [3:0] flagCount;
    logic acceptNow;
    logic rejectNow;
    pdpExecPkg::execOp decodedOp;

    // Memory flags in the upper bits, operate flags below
    assign allFlags = {memCode.opAnd, memCode.opTad, memCode.opIsz,
                       memCode.opDca, memCode.opJms, memCode.opJmp, op7Code};

    always_comb begin
        flagCount = '0;
        for (int i = 0; i < $bits(allFlags); i++) begin
            flagCount = flagCount + {3'b000, allFlags[i]};
        end
    end

    // Flags are only looked at while the sequencer is idle
    assign acceptNow = !busy && (flagCount == 4'd1);
    assign rejectNow = !busy && (flagCount > 4'd1);

    always_comb begin
        if (memCode.opAnd)         decodedOp = pdpExecPkg::execAnd;
        else if (memCode.opTad)    decodedOp = pdpExecPkg::execTad;
        else if (memCode.opIsz)    decodedOp = pdpExecPkg::execIsz;
        else if (memCode.opDca)    decodedOp = pdpExecPkg::execDca;
        else if (memCode.opJms)    decodedOp = pdpExecPkg::execJms;
        else if (memCode.opJmp)    decodedOp = pdpExecPkg::execJmp;
        else if (op7Code.opIac)    decodedOp = pdpExecPkg::execIac;
        else if (op7Code.opCma)    decodedOp = pdpExecPkg::execCma;
        else if (op7Code.opCml)    decodedOp = pdpExecPkg::execCml;
        else if (op7Code.opCll)    decodedOp = pdpExecPkg::execCll;
        else if (op7Code.opCla1)   decodedOp = pdpExecPkg::execCla1;
        else if (op7Code.opClaCll) decodedOp = pdpExecPkg::execClaCll;
        else                       decodedOp = pdpExecPkg::execNop;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cmdValid <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            cmdValid <= acceptNow;
            illegalInstr <= rejectNow;
        end
    end

    // Command stays put for the whole execution, nothing new is taken while busy
    always_ff @(posedge clk) begin
        if (acceptNow) begin
            command.op <= decodedOp;
            command.operand <= memCode.memInstAddr;
        end
    end

endmodule

`default_nettype wire

//--- design/memPort.sv
// Output stage of the execution unit
// Registers the posted request onto the memory bus and keeps the word
// returned for the last read, so the sequencer sees it until the next read
`timescale 1ns/100ps
`default_nettype none

module memPort (
    input  wire logic                               clk,
    input  wire logic                               reset_n,
    input  wire pdpExecPkg::memRequest              memReq,
    input  wire logic [pdpExecPkg::dataWidth-1:0]   rdData,
    output pdpExecPkg::memRequest                   memBus,
    output logic [pdpExecPkg::dataWidth-1:0]        rdDataSeen
);

    logic rdReqQ;
    logic wrReqQ;
    logic [pdpExecPkg::addrWidth-1:0] addressQ;
    logic [pdpExecPkg::dataWidth-1:0] wrDataQ;
    logic readPending;
    logic [pdpExecPkg::dataWidth-1:0] holdData;

    // Strobes and read tracking
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rdReqQ <= 1'b0;
            wrReqQ <= 1'b0;
            readPending <= 1'b0;
        end else begin
            rdReqQ <= memReq.rdReq;
            wrReqQ <= memReq.wrReq;
            // Memory answers in the cycle after the external strobe
            readPending <= rdReqQ;
        end
    end

    always_ff @(posedge clk) begin
        addressQ <= memReq.address;
        wrDataQ <= memReq.wrData;
        if (readPending) begin
            holdData <= rdData;
        end
    end

    assign memBus = '{
        rdReq:   rdReqQ,
        wrReq:   wrReqQ,
        address: addressQ,
        wrData:  wrDataQ
    };

    // Live word in the return cycle, held copy afterwards
    assign rdDataSeen = readPending ? rdData : holdData;

endmodule

`default_nettype wire

//--- design/pdpExecPkg.sv
// Shared definitions for the PDP-8 style execution unit
// Holds the widths, reset address, per-class cycle counts and the structs
// that travel between the decoder, the three stages and the memory
`default_nettype none

package pdpExecPkg;

    // PDP-8 word and address widths
    localparam int addrWidth = 12;
    localparam int dataWidth = 12;

    // Program counter value after reset
    localparam logic [addrWidth-1:0] startAddress = 12'o200;

    // Step counter width, wide enough for the longest instruction
    localparam int stepWidth = 3;

    // Stall length per instruction class, in cycles after the accept edge
    localparam logic [stepWidth-1:0] andTadCycles = 3'd4;
    localparam logic [stepWidth-1:0] iszCycles = 3'd5;
    localparam logic [stepWidth-1:0] shortCycles = 3'd3;

    // Memory reference instructions as flagged by the decoder
    typedef struct packed {
        logic opAnd;
        logic opTad;
        logic opIsz;
        logic opDca;
        logic opJms;
        logic opJmp;
        logic [addrWidth-1:0] memInstAddr;
    } memOpcode;

    // Operate group instructions kept by this unit
    typedef struct packed {
        logic opNop;
        logic opIac;
        logic opCma;
        logic opCml;
        logic opCll;
        logic opCla1;
        logic opClaCll;
    } op7Opcode;

    // One encoding per supported operation
    typedef enum logic [3:0] {
        execAnd,
        execTad,
        execIsz,
        execDca,
        execJms,
        execJmp,
        execNop,
        execIac,
        execCma,
        execCml,
        execCll,
        execCla1,
        execClaCll
    } execOp;

    // Accepted instruction handed from intake to the sequencer
    typedef struct packed {
        execOp op;
        logic [addrWidth-1:0] operand;
    } execCommand;

    // Single-cycle memory request, read and write share the address
    typedef struct packed {
        logic rdReq;
        logic wrReq;
        logic [addrWidth-1:0] address;
        logic [dataWidth-1:0] wrData;
    } memRequest;

endpackage

`default_nettype wire

//--- design/pdpExecUnit.sv
// Top level of the PDP-8 style execution unit
// Takes decoded opcodes from the instruction decoder, stalls it while an
// instruction runs and drives single-cycle requests to the memory
`timescale 1ns/100ps
`default_nettype none

module pdpExecUnit (
    input  wire logic                               clk,
    input  wire logic                               reset_n,
    input  wire pdpExecPkg::memOpcode               memCode,
    input  wire pdpExecPkg::op7Opcode               op7Code,
    input  wire logic [pdpExecPkg::dataWidth-1:0]   rdData,
    output pdpExecPkg::memRequest                   memBus,
    output logic                                    stall,
    output logic [pdpExecPkg::addrWidth-1:0]        pcValue,
    output logic [pdpExecPkg::dataWidth-1:0]        accValue,
    output logic                                    linkValue,
    output logic                                    illegalInstr
);

    pdpExecPkg::execCommand command;
    pdpExecPkg::memRequest memReq;
    logic cmdValid;
    logic busy;
    logic [pdpExecPkg::dataWidth-1:0] rdDataSeen;

    instrIntake intake (
        .clk          (clk),
        .reset_n      (reset_n),
        .memCode      (memCode),
        .op7Code      (op7Code),
        .busy         (busy),
        .command      (command),
        .cmdValid     (cmdValid),
        .illegalInstr (illegalInstr)
    );

    execSequencer sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .command    (command),
        .cmdValid   (cmdValid),
        .rdDataSeen (rdDataSeen),
        .busy       (busy),
        .memReq     (memReq),
        .pcValue    (pcValue),
        .accValue   (accValue),
        .linkValue  (linkValue)
    );

    memPort port (
        .clk        (clk),
        .reset_n    (reset_n),
        .memReq     (memReq),
        .rdData     (rdData),
        .memBus     (memBus),
        .rdDataSeen (rdDataSeen)
    );

    // Decoder is held off for as long as the sequencer is busy
    assign stall = busy;

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the execution unit testbench with Verilator.
# Exits non-zero when the build fails, the simulator fails,
# or the log reports a failing test.

cd "$(dirname "$0")" || exit 1

logFile=sim.log
failText="Some tests failed"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pdpExecUnitTb -Mdir obj_dir -o simv -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+100000 > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "$failText" "$logFile"; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi
exit 0

//--- sources.f
design/pdpExecPkg.sv
design/instrIntake.sv
design/execSequencer.sv
design/memPort.sv
design/pdpExecUnit.sv
bench/pdpExecUnit_assert.sv
bench/pdpExecUnitTb.sv
